//--- eeprom_dump_bridge.sv
// eeprom dump bridge, bytes in to 16-bit words
// and stored words back out as bytes
`timescale 1ns/100ps

module eeprom_dump_bridge (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ioctl_wr,
    input  logic                           ioctl_ram,
    input  logic [rom_load_pkg::eeprom_aw:0] ioctl_addr,
    input  logic [7:0]                     ioctl_data,
    input  logic [15:0]                    dump_dout,
    output logic [15:0]                    dump_din,
    output logic [rom_load_pkg::eeprom_aw-1:0] dump_addr,
    output logic                           dump_we,
    output logic [7:0]                     ioctl_data2sd
);
    import rom_load_pkg::*;

    logic ee_wr;

    assign ee_wr     = ioctl_wr && ioctl_ram;
    assign dump_addr = ioctl_addr[eeprom_aw:1]; // word address
    assign ioctl_data2sd = ioctl_addr[0] ? dump_dout[15:8] : dump_dout[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            dump_we <= 1'b0;
        end else begin
            dump_we <= ee_wr;
        end
    end

    // odd byte to the upper half, even to the lower
    always_ff @(posedge clk) begin
        if (ee_wr && ioctl_addr[0]) dump_din[15:8] <= ioctl_data;
        if (ee_wr && !ioctl_addr[0]) dump_din[7:0] <= ioctl_data;
    end

endmodule

//--- rom_header_decode.sv
// header decode for the rom download
// region starts, decryption flags, config and key loader strobes
`timescale 1ns/100ps

module rom_header_decode (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             ioctl_wr,
    input  logic                             ioctl_ram,
    input  logic [rom_load_pkg::byte_aw-1:0] ioctl_addr,
    input  logic [7:0]                       ioctl_data,
    input  logic                             downloading,
    output rom_load_pkg::region_starts_t     starts,
    output logic                             decrypt,
    output logic                             key_bit,
    output logic                             cfg_we,
    output logic                             kabuki_we
);
    import rom_load_pkg::*;

    logic       dl_wr;
    logic       in_start;
    logic       in_cfg;
    logic       in_key;
    logic [1:0] kabuki_sr; // two cycle pulse for the key loader

    assign dl_wr    = ioctl_wr && !ioctl_ram;
    assign in_start = ioctl_addr < start_bytes;
    assign in_cfg   = (ioctl_addr >= cfg_first) && (ioctl_addr <= cfg_last);
    assign in_key   = (ioctl_addr >= key_first) && (ioctl_addr <= key_last);

    assign kabuki_we = kabuki_sr[0];

    // little endian byte shift into the starts word
    always_ff @(posedge clk) begin
        if (reset) begin
            starts <= '0;
        end else if (dl_wr && in_start) begin
            starts <= {ioctl_data, starts[63:8]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decrypt <= 1'b0;
        end else if (dl_wr && ioctl_addr == cfg_byte) begin
            decrypt <= ioctl_data[7];
        end else if (!downloading) begin
            decrypt <= 1'b0; // flag only lives for one download
        end
    end

    // key bit picks the byte parity that gets decrypted
    always_ff @(posedge clk) begin
        if (dl_wr && ioctl_addr == cfg_byte) begin
            key_bit <= ioctl_data[6];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_we <= 1'b0;
        end else begin
            cfg_we <= dl_wr && in_cfg;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            kabuki_sr <= 2'b00;
        end else if (dl_wr && in_key) begin
            kabuki_sr <= 2'b11;
        end else begin
            kabuki_sr <= {1'b0, kabuki_sr[1]};
        end
    end

endmodule

//--- rom_load_pkg.sv
// sizes, header byte map, region offsets and decryption constants
// region enum plus the header and programming request structs
package rom_load_pkg;

    localparam int byte_aw   = 25; // download byte address
    localparam int prog_aw   = 12; // programming word address
    localparam int eeprom_aw = 7;

    // header byte map
    localparam logic [byte_aw-1:0] start_bytes = 25'd8;
    localparam logic [byte_aw-1:0] cfg_first   = 25'd8;
    localparam logic [byte_aw-1:0] cfg_last    = 25'd39;
    localparam logic [byte_aw-1:0] cfg_byte    = 25'd39; // bit 7 decrypt, bit 6 key
    localparam logic [byte_aw-1:0] key_first   = 25'd48;
    localparam logic [byte_aw-1:0] key_last    = 25'd58;
    localparam logic [byte_aw-1:0] bulk_start  = 25'd64;

    // word offsets of each region in the programming space
    localparam logic [prog_aw-1:0] cpu_off = 12'd0;
    localparam logic [prog_aw-1:0] snd_off = 12'd1024;
    localparam logic [prog_aw-1:0] pcm_off = 12'd2048;
    localparam logic [prog_aw-1:0] gfx_off = 12'd3072;

    typedef struct packed {
        logic [7:0]      on_clear; // constant applies when the data bit is 0
        logic [7:0][7:0] xor_val;  // one constant per data bit
    } decrypt_table_t;

    // cpu byte scramble, index 7 first
    localparam decrypt_table_t decrypt_table = '{
        on_clear: 8'b1000_1000,
        xor_val:  {8'h88, 8'h08, 8'h06, 8'h40, 8'h50, 8'h01, 8'h21, 8'h04}
    };

    typedef enum logic [2:0] {
        rgn_cpu,
        rgn_snd,
        rgn_pcm,
        rgn_gfx,
        rgn_dsp
    } rom_region_e;

    // region starts in 1 KB units, snd in the low bits
    typedef struct packed {
        logic [15:0] dsp;
        logic [15:0] gfx;
        logic [15:0] pcm;
        logic [15:0] snd;
    } region_starts_t;

    typedef struct packed {
        logic [prog_aw-1:0] addr;
        logic [7:0]         data;
        logic [1:0]         mask;    // active low byte lanes
        logic [1:0]         bank;
        logic               is_prog; // bulk byte for sdram
        logic               is_dsp;  // bulk byte for the dsp rom
    } prog_req_t;

endpackage

//--- rom_loader_top.sv
// rom download path top level
// header decode, region map, sdram writer and eeprom bridge
`timescale 1ns/100ps

module rom_loader_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               downloading,
    input  logic [rom_load_pkg::byte_aw-1:0]   ioctl_addr,
    input  logic [7:0]                         ioctl_data,
    input  logic                               ioctl_wr,
    input  logic                               ioctl_ram,
    output logic [7:0]                         ioctl_data2sd,
    output logic [rom_load_pkg::prog_aw-1:0]   prog_addr,
    output logic [15:0]                        prog_data,
    output logic [1:0]                         prog_mask,
    output logic [1:0]                         prog_ba,
    output logic                               prog_we,
    output logic                               prom_we,
    input  logic                               prog_rdy,
    output logic                               cfg_we,
    output logic                               kabuki_we,
    output logic                               busy,
    output logic [15:0]                        dump_din,
    input  logic [15:0]                        dump_dout,
    output logic [rom_load_pkg::eeprom_aw-1:0] dump_addr,
    output logic                               dump_we
);
    import rom_load_pkg::*;

    region_starts_t starts;
    logic           decrypt;
    logic           key_bit;
    prog_req_t      req;

    rom_header_decode u_header (
        .clk, .reset, .ioctl_wr, .ioctl_ram, .ioctl_addr, .ioctl_data,
        .downloading, .starts, .decrypt, .key_bit, .cfg_we, .kabuki_we
    );

    rom_region_map u_map (
        .ioctl_addr, .ioctl_data, .starts, .decrypt, .key_bit, .req
    );

    sdram_prog_writer u_writer (
        .clk, .reset, .ioctl_wr, .ioctl_ram, .downloading, .req, .prog_rdy,
        .prog_addr, .prog_data, .prog_mask, .prog_ba, .prog_we, .prom_we, .busy
    );

    // only the low address bits reach the eeprom
    eeprom_dump_bridge u_dump (
        .clk,
        .reset,
        .ioctl_wr,
        .ioctl_ram,
        .ioctl_addr    (ioctl_addr[eeprom_aw:0]),
        .ioctl_data,
        .dump_dout,
        .dump_din,
        .dump_addr,
        .dump_we,
        .ioctl_data2sd
    );

endmodule

//--- rom_region_map.sv
// bulk byte classification into rom regions
// word address, bank, lane mask and cpu byte decryption
`timescale 1ns/100ps

module rom_region_map (
    input  logic [rom_load_pkg::byte_aw-1:0] ioctl_addr,
    input  logic [7:0]                       ioctl_data,
    input  rom_load_pkg::region_starts_t     starts,
    input  logic                             decrypt,
    input  logic                             key_bit,
    output rom_load_pkg::prog_req_t          req
);
    import rom_load_pkg::*;

    logic [byte_aw-1:0] bulk_off;  // byte offset past the header
    logic [15:0]        kb_idx;    // 1 KB index of the bulk byte
    logic               is_bulk;
    rom_region_e        region;
    logic [15:0]        rgn_start;
    logic [prog_aw-1:0] rgn_off;
    logic [byte_aw-1:0] rel_off;   // byte offset inside the region
    logic               do_dec;
    logic [7:0]         dec_data;

    assign bulk_off = ioctl_addr - bulk_start;
    assign is_bulk  = ioctl_addr >= bulk_start;
    assign kb_idx   = {1'b0, bulk_off[byte_aw-1:10]};

    always_comb begin
        if (kb_idx < starts.snd) begin
            region = rgn_cpu;
        end else if (kb_idx < starts.pcm) begin
            region = rgn_snd;
        end else if (kb_idx < starts.gfx) begin
            region = rgn_pcm;
        end else if (kb_idx < starts.dsp) begin
            region = rgn_gfx;
        end else begin
            region = rgn_dsp;
        end
    end

    // cpu and dsp both count from the start of the bulk data
    always_comb begin
        case (region)
            rgn_snd: begin
                rgn_start = starts.snd;
                rgn_off   = snd_off;
            end
            rgn_pcm: begin
                rgn_start = starts.pcm;
                rgn_off   = pcm_off;
            end
            rgn_gfx: begin
                rgn_start = starts.gfx;
                rgn_off   = gfx_off;
            end
            rgn_cpu: begin
                rgn_start = 16'd0;
                rgn_off   = cpu_off;
            end
            default: begin
                rgn_start = 16'd0;
                rgn_off   = '0;
            end
        endcase
    end

    assign rel_off = bulk_off - {rgn_start[byte_aw-11:0], 10'd0};

    // keyed parity bytes in the upper half of the cpu rom
    assign do_dec = is_bulk && region == rgn_cpu && decrypt &&
                    bulk_off[19] && (bulk_off[0] ^ key_bit);

    always_comb begin
        dec_data = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (ioctl_data[i] ^ decrypt_table.on_clear[i]) begin
                dec_data = dec_data ^ decrypt_table.xor_val[i];
            end
        end
    end

    always_comb begin
        req.addr    = rel_off[prog_aw:1] + rgn_off;
        req.data    = do_dec ? dec_data : ioctl_data;
        req.mask    = bulk_off[0] ? 2'b01 : 2'b10; // even byte goes low lane
        req.is_prog = is_bulk && region != rgn_dsp;
        req.is_dsp  = is_bulk && region == rgn_dsp;
        case (region)
            rgn_cpu: req.bank = 2'd3;
            rgn_gfx: req.bank = 2'd2;
            default: req.bank = 2'd1;
        endcase
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the rom loader testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_rom_loader -f tb.f

./obj_dir/Vtb_rom_loader > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- sdram_prog_writer.sv
// sdram programming port writer
// holds each write until prog_rdy, clears the space after download
`timescale 1ns/100ps

module sdram_prog_writer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             ioctl_wr,
    input  logic                             ioctl_ram,
    input  logic                             downloading,
    input  rom_load_pkg::prog_req_t          req,
    input  logic                             prog_rdy,
    output logic [rom_load_pkg::prog_aw-1:0] prog_addr,
    output logic [15:0]                      prog_data,
    output logic [1:0]                       prog_mask,
    output logic [1:0]                       prog_ba,
    output logic                             prog_we,
    output logic                             prom_we,
    output logic                             busy
);
    import rom_load_pkg::*;

    logic       dl_seen;   // a download write happened
    logic       clr_ram;   // clear sweep running
    logic [7:0] data_q;
    logic       load_req;
    logic       start_clr;
    logic       clr_done;
    logic       clr_step;

    assign load_req  = ioctl_wr && !ioctl_ram;
    assign start_clr = !load_req && !clr_ram && !downloading && dl_seen;
    assign clr_done  = clr_ram && prog_we && prog_rdy;
    assign clr_step  = !load_req && clr_done && !(&prog_addr);

    assign prog_data = {2{data_q}};

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
            busy    <= 1'b0;
            clr_ram <= 1'b0;
            dl_seen <= 1'b0;
        end else if (load_req) begin
            dl_seen <= 1'b1;
            clr_ram <= 1'b0;
            busy    <= 1'b1;
            prog_we <= req.is_prog;
            prom_we <= req.is_dsp; // any other write drops it
        end else if (clr_ram) begin
            if (clr_done) begin
                prog_we <= 1'b0;
                if (&prog_addr) begin
                    clr_ram <= 1'b0; // last word written
                    busy    <= 1'b0;
                end
            end else begin
                prog_we <= 1'b1;
            end
        end else begin
            if (!downloading || prog_rdy) prog_we <= 1'b0;
            if (!downloading) begin
                prom_we <= 1'b0;
                if (dl_seen) begin
                    clr_ram <= 1'b1;
                    prog_we <= 1'b1;
                    dl_seen <= 1'b0;
                end
            end
        end
    end

    // write payload, zeroed for the sweep
    always_ff @(posedge clk) begin
        if (load_req) begin
            prog_addr <= req.addr;
            data_q    <= req.data;
            prog_mask <= req.mask;
            prog_ba   <= req.bank;
        end else if (start_clr) begin
            prog_addr <= '0;
            data_q    <= 8'h00;
            prog_mask <= 2'b00; // both lanes
            prog_ba   <= 2'd0;
        end else if (clr_step) begin
            prog_addr <= prog_addr + 1'b1;
        end
    end

endmodule

//--- tb.f
rom_load_pkg.sv
rom_header_decode.sv
rom_region_map.sv
sdram_prog_writer.sv
eeprom_dump_bridge.sv
rom_loader_top.sv
tb_sdram_model.sv
tb_rom_loader.sv

//--- tb_rom_loader.sv
// testbench for the rom download path
// stimulus table loop, sdram responder, clear sweep check and timeout
`timescale 1ns/100ps

module tb_rom_loader;
    import rom_load_pkg::*;

    typedef struct packed {
        logic [byte_aw-1:0] addr;
        logic [7:0]         data;
        logic               ram;
        logic               cfg;    // one cycle cfg_we
        logic               kabuki; // two cycle key pulse
        logic               prog;   // write seen by the model
        logic               prom;
        logic               dump;
        logic [11:0]        waddr;  // prog or dump word address
        logic [15:0]        word;   // prog_data or dump_din
        logic [1:0]         mask;
        logic [1:0]         bank;
        logic [7:0]         rd;     // ioctl_data2sd
    } row_t;

    localparam int n_rows      = 29;
    localparam int sweep_words = 4096;
    localparam int cycle_limit = n_rows * 10 + sweep_words * 6 + 100;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 downloading;
    logic [byte_aw-1:0]   ioctl_addr;
    logic [7:0]           ioctl_data;
    logic                 ioctl_wr;
    logic                 ioctl_ram;
    logic [7:0]           ioctl_data2sd;
    logic [prog_aw-1:0]   prog_addr;
    logic [15:0]          prog_data;
    logic [1:0]           prog_mask;
    logic [1:0]           prog_ba;
    logic                 prog_we;
    logic                 prom_we;
    logic                 prog_rdy;
    logic                 cfg_we;
    logic                 kabuki_we;
    logic                 busy;
    logic [15:0]          dump_din;
    logic [15:0]          dump_dout;
    logic [eeprom_aw-1:0] dump_addr;
    logic                 dump_we;
    logic [prog_aw-1:0]   last_addr;
    logic [15:0]          last_data;
    logic [1:0]           last_mask;
    logic [1:0]           last_ba;
    int                   wr_count;

    row_t  rows[n_rows];
    string names[n_rows];
    string cur_name;
    int    n_filled = 0;
    int    checks = 0;
    int    errors = 0;
    int    cycles = 0;

    rom_loader_top dut (.*);

    tb_sdram_model u_sdram (
        .clk, .reset, .prog_addr, .prog_data, .prog_mask, .prog_ba, .prog_we, .prog_rdy,
        .dump_addr, .dump_dout, .last_addr, .last_data, .last_mask, .last_ba, .wr_count
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run not done after %0d cycles", cycle_limit);
            $display("summary: %0d checks, %0d errors", checks, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic compare_value(input string what, input logic [15:0] exp,
                                 input logic [15:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
        end
    endtask

    // flags are cfg, kabuki, prog, prom, dump
    task automatic add_row(input string name, input logic [byte_aw-1:0] addr,
                           input logic [7:0] data, input logic ram, input logic [4:0] flags,
                           input logic [11:0] waddr, input logic [15:0] word,
                           input logic [1:0] mask, input logic [1:0] bank,
                           input logic [7:0] rd);
        names[n_filled] = name;
        rows[n_filled]  = '{addr, data, ram, flags[4], flags[3], flags[2], flags[1],
                            flags[0], waddr, word, mask, bank, rd};
        n_filled++;
    endtask

    task automatic fill_table();
        // name           addr       data  ram flags    waddr  word     mask bank rd
        add_row("start0",    'h00,     'h01, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("start1",    'h01,     'h00, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("start2",    'h02,     'h02, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("start3",    'h03,     'h00, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("start4",    'h04,     'h03, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("start5",    'h05,     'h00, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("start6",    'h06,     'h04, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("start7",    'h07,     'h00, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("cfg_flags", 'h27,     'h80, 0, 'b10000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("key_byte",  'h30,     'h5a, 0, 'b01000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("cpu_even",  'h140,    'h11, 0, 'b00100, 'h080, 'h1111, 'b10, 3, 'h00);
        add_row("cpu_odd",   'h141,    'h22, 0, 'b00100, 'h080, 'h2222, 'b01, 3, 'h00);
        add_row("snd_even",  'h450,    'h33, 0, 'b00100, 'h408, 'h3333, 'b10, 1, 'h00);
        add_row("pcm_odd",   'h861,    'h44, 0, 'b00100, 'h810, 'h4444, 'b01, 1, 'h00);
        add_row("gfx_even",  'h103e,   'h55, 0, 'b00100, 'hdff, 'h5555, 'b10, 2, 'h00);
        add_row("dsp_byte",  'h1046,   'h66, 0, 'b00010, 'h803, 'h0000, 'b00, 0, 'h00);
        // cpu region grows past offset bit 19
        add_row("restart0",  'h00,     'h00, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("restart1",  'h01,     'h04, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("restart2",  'h02,     'h01, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("restart3",  'h03,     'h04, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("restart4",  'h04,     'h02, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("restart5",  'h05,     'h04, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("restart6",  'h06,     'h03, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("restart7",  'h07,     'h04, 0, 'b00000, 'h000, 'h0000, 'b00, 0, 'h00);
        add_row("dec_odd_a", 'h80041,  'h5a, 0, 'b00100, 'h000, 'he1e1, 'b01, 3, 'h00);
        add_row("dec_odd_b", 'h80043,  'h00, 0, 'b00100, 'h001, 'hd8d8, 'b01, 3, 'h00);
        add_row("dec_even",  'h80042,  'h5a, 0, 'b00100, 'h001, 'h5a5a, 'b10, 3, 'h00);
        add_row("ee_even",   'h10,     'h3c, 1, 'b00001, 'h008, 'h003c, 'b00, 0, 'h08);
        add_row("ee_odd",    'h11,     'hc3, 1, 'b00001, 'h008, 'hc33c, 'b00, 0, 'h88);
    endtask

    task automatic apply_row(input int i);
        row_t        r;
        int          count_before;
        logic [15:0] din_mask;
        r            = rows[i];
        cur_name     = names[i];
        count_before = wr_count;
        @(negedge clk);
        ioctl_addr = r.addr;
        ioctl_data = r.data;
        ioctl_ram  = r.ram;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        compare_value("cfg_we", r.cfg, cfg_we);
        compare_value("kabuki_we", r.kabuki, kabuki_we);
        compare_value("prog_we", r.prog, prog_we);
        compare_value("prom_we", r.prom, prom_we);
        compare_value("dump_we", r.dump, dump_we);
        if (r.prom) compare_value("prog_addr", r.waddr, prog_addr);
        if (r.dump) begin
            din_mask = r.addr[0] ? 16'hffff : 16'h00ff; // even byte fills only the low half
            compare_value("dump_din", r.word & din_mask, dump_din & din_mask);
            compare_value("dump_addr", r.waddr, dump_addr);
            compare_value("ioctl_data2sd", r.rd, ioctl_data2sd);
        end
        @(negedge clk);
        compare_value("cfg_we after", 1'b0, cfg_we);
        compare_value("kabuki_we second", r.kabuki, kabuki_we);
        compare_value("dump_we after", 1'b0, dump_we);
        @(negedge clk);
        compare_value("kabuki_we third", 1'b0, kabuki_we);
        while (prog_we) @(negedge clk);
        compare_value("write count", count_before + r.prog, wr_count);
        if (r.prog) begin
            compare_value("model addr", r.waddr, last_addr);
            compare_value("model data", r.word, last_data);
            compare_value("model mask", r.mask, last_mask);
            compare_value("model bank", r.bank, last_ba);
        end
    endtask

    task automatic run_sweep();
        int seen;
        int last_count;
        seen       = 0;
        last_count = wr_count;
        cur_name   = "clear_sweep";
        @(negedge clk);
        downloading = 1'b0;
        @(negedge clk);
        compare_value("busy", 1'b1, busy);
        while (busy || wr_count != last_count) begin
            if (wr_count != last_count) begin
                compare_value("addr", seen, last_addr); // one word per poll at most
                compare_value("data", 16'h0000, last_data);
                compare_value("mask", 2'b00, last_mask);
                compare_value("bank", 2'd0, last_ba);
                seen++;
                last_count = wr_count;
            end
            @(negedge clk);
        end
        compare_value("word count", sweep_words, seen);
    endtask

    initial begin
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = 8'h00;
        ioctl_wr    = 1'b0;
        ioctl_ram   = 1'b0;
        fill_table();
        repeat (3) @(negedge clk);
        reset    = 1'b0;
        cur_name = "reset";
        compare_value("prog_we", 1'b0, prog_we);
        compare_value("prom_we", 1'b0, prom_we);
        compare_value("cfg_we", 1'b0, cfg_we);
        compare_value("kabuki_we", 1'b0, kabuki_we);
        compare_value("dump_we", 1'b0, dump_we);
        compare_value("busy", 1'b0, busy);
        downloading = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
            if (i == 0) compare_value("busy", 1'b1, busy);
        end
        run_sweep();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb_sdram_model.sv
// programming port responder for the rom loader testbench
// random ack delay, last write record and eeprom read data
`timescale 1ns/100ps

module tb_sdram_model (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [rom_load_pkg::prog_aw-1:0]   prog_addr,
    input  logic [15:0]                        prog_data,
    input  logic [1:0]                         prog_mask,
    input  logic [1:0]                         prog_ba,
    input  logic                               prog_we,
    output logic                               prog_rdy,
    input  logic [rom_load_pkg::eeprom_aw-1:0] dump_addr,
    output logic [15:0]                        dump_dout,
    output logic [rom_load_pkg::prog_aw-1:0]   last_addr,
    output logic [15:0]                        last_data,
    output logic [1:0]                         last_mask,
    output logic [1:0]                         last_ba,
    output int                                 wr_count
);
    import rom_load_pkg::*;

    integer seed = 63257;
    int     wait_left;
    logic   waiting;

    // stored eeprom word, a pattern of the whole word address
    assign dump_dout = {1'b1, dump_addr, 1'b0, dump_addr};

    always @(posedge clk) begin : ack_fsm
        int delay;
        if (reset) begin
            prog_rdy  <= 1'b0;
            waiting   <= 1'b0;
            wait_left <= 0;
            wr_count  <= 0;
        end else if (prog_rdy) begin
            prog_rdy  <= 1'b0; // writer drops prog_we on this edge
            last_addr <= prog_addr;
            last_data <= prog_data;
            last_mask <= prog_mask;
            last_ba   <= prog_ba;
            wr_count  <= wr_count + 1;
        end else if (waiting) begin
            if (wait_left == 0) begin
                prog_rdy <= 1'b1;
                waiting  <= 1'b0;
            end else begin
                wait_left <= wait_left - 1;
            end
        end else if (prog_we) begin
            delay = {$random(seed)} % 4; // 0 to 3 cycles
            if (delay == 0) begin
                prog_rdy <= 1'b1;
            end else begin
                waiting   <= 1'b1;
                wait_left <= delay - 1;
            end
        end
    end

endmodule
